// ==== compile.f ====
design/rom_loader_pkg.sv
design/rom_write_if.sv
design/ioctl_sync.sv
design/word_packer.sv
design/axil_write_master.sv
design/reset_sequencer.sv
design/rom_loader_top.sv
tb/rom_loader_assert.sv
tb/rom_loader_tb.sv

// ==== tb/rom_loader_tb.sv ====
//////////////////////////////
// Testbench for the ROM download loader
// Host stream plus AXI slave model, each write checked against a reference
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rom_loader_tb;
	import rom_loader_pkg::*;

	localparam int CLK_PERIOD = 8;
	// Longest wait on ioctl_wait or system_reset
	localparam int WAIT_LIMIT = 1000;
	// Rough length of each test in cycles
	localparam int PAUSE_TEST_CYCLES = 600;
	localparam int PACK_TEST_CYCLES = 400;
	localparam int RESET_TEST_CYCLES = 300;
	localparam int STALL_TEST_CYCLES = 1200;
	localparam int TAIL_TEST_CYCLES = 800;
	localparam int HW_RESET_TEST_CYCLES = 700;
	localparam int WATCHDOG_CYCLES = 2 * (PAUSE_TEST_CYCLES + PACK_TEST_CYCLES
		+ RESET_TEST_CYCLES + STALL_TEST_CYCLES + TAIL_TEST_CYCLES + HW_RESET_TEST_CYCLES);

	// One AXI write, seen on the bus or expected
	typedef struct packed {
		axi_addr_t addr;
		word_t     data;
		strb_t     strb;
	} write_t;

	logic       clk_sys = 1'b0;
	logic       hardware_reset;
	logic       ioctl_download;
	logic       ioctl_wr;
	byte_addr_t ioctl_addr;
	half_t      ioctl_dout;
	logic       ioctl_wait;
	axi_addr_t  awaddr;
	logic       awvalid;
	logic       awready = 1'b0;
	word_t      wdata;
	strb_t      wstrb;
	logic       wvalid;
	logic       wready = 1'b0;
	logic       bvalid = 1'b0;
	logic       bready;
	logic       system_reset;

	// Slave model state
	integer seed;
	logic   stall_enable = 1'b0;
	logic   aw_seen = 1'b0;
	logic   w_seen = 1'b0;
	logic   b_seen = 1'b0;
	write_t seen;
	write_t pending;
	logic   aw_taken = 1'b0;
	logic   w_taken = 1'b0;
	logic   aw_counting = 1'b0;
	logic   w_counting = 1'b0;
	logic   b_counting = 1'b0;
	int     aw_delay;
	int     w_delay;
	int     b_delay;

	// Download as the DUT saw it at the last edge
	logic   download_seen = 1'b0;

	// Scoreboard
	write_t actual_q[$];
	write_t expected_q[$];
	int     write_count = 0;
	int     error_count = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	rom_loader_top rom_loader_top_inst (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.wready         (wready),
		.bvalid         (bvalid),
		.bready         (bready),
		.system_reset   (system_reset)
	);

	//////////////////////////////
	// Reference and slave model
	//////////////////////////////

	// Second halfword above the first, word aligned byte address, all lanes
	function automatic write_t expected_word(input half_t first, input half_t second,
			input byte_addr_t first_addr);
		write_t result;
		result.data = {second, first};
		result.addr = {7'd0, first_addr[24:2], 2'b00};
		result.strb = 4'b1111;
		return result;
	endfunction

	// Stall of 0 to 4 cycles, none when stalls are off
	function automatic int stall_cycles();
		if (stall_enable) begin
			return $unsigned($random(seed)) % 5;
		end
		return 0;
	endfunction

	// Counts down one channel's stall, then raises its ready or valid
	task automatic stall_step(inout logic counting, inout int delay, inout logic ready);
		if (!counting) begin
			counting = 1'b1;
			delay = stall_cycles();
		end
		if (delay == 0) begin
			ready = 1'b1;
			counting = 1'b0;
		end else begin
			delay = delay - 1;
		end
	endtask

	// Decides on values sampled a cycle back, which held up to this edge
	always @(posedge clk_sys) begin
		#1;
		if (aw_seen && awready) begin
			pending.addr = seen.addr;
			aw_taken = 1'b1;
			awready = 1'b0;
		end
		if (w_seen && wready) begin
			pending.data = seen.data;
			pending.strb = seen.strb;
			w_taken = 1'b1;
			wready = 1'b0;
		end
		// Write response taken, the write is complete
		if (b_seen && bvalid) begin
			actual_q.push_back(pending);
			write_count++;
			bvalid = 1'b0;
			aw_taken = 1'b0;
			w_taken = 1'b0;
		end
		if (hardware_reset) begin
			awready = 1'b0;
			wready = 1'b0;
			bvalid = 1'b0;
			aw_taken = 1'b0;
			w_taken = 1'b0;
			aw_counting = 1'b0;
			w_counting = 1'b0;
			b_counting = 1'b0;
		end else begin
			if (awvalid && !awready) begin
				stall_step(aw_counting, aw_delay, awready);
			end
			if (wvalid && !wready) begin
				stall_step(w_counting, w_delay, wready);
			end
			// Response only once both channels are through
			if (aw_taken && w_taken && !bvalid) begin
				stall_step(b_counting, b_delay, bvalid);
			end
		end
		aw_seen = awvalid;
		w_seen = wvalid;
		b_seen = bready;
		seen.addr = awaddr;
		seen.data = wdata;
		seen.strb = wstrb;
	end

	//////////////////////////////
	// Compare and monitor
	//////////////////////////////

	// Check failures plus bound assertion failures
	function automatic int total_errors();
		return error_count
			+ rom_loader_top_inst.axil_write_master_inst.rom_loader_assert_inst.failures;
	endfunction

	// Writes must match the expected words in order
	always @(negedge clk_sys) begin
		write_t got;
		write_t want;
		while (actual_q.size() > 0) begin
			got = actual_q.pop_front();
			if (expected_q.size() == 0) begin
				$display("Fail at %0t: unexpected write to %h", $time, got.addr);
				error_count++;
			end else begin
				want = expected_q.pop_front();
				if (got.addr != want.addr) begin
					$display("Fail at %0t: awaddr %h, expected %h", $time, got.addr, want.addr);
					error_count++;
				end
				if (got.data != want.data) begin
					$display("Fail at %0t: wdata %h, expected %h", $time, got.data, want.data);
					error_count++;
				end
				if (got.strb != want.strb) begin
					$display("Fail at %0t: wstrb %b, expected %b", $time, got.strb, want.strb);
					error_count++;
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		download_seen <= ioctl_download;
	end

	// System reset must cover the whole download once the DUT has seen it
	always @(negedge clk_sys) begin
		if (!hardware_reset && download_seen && ioctl_download && !system_reset) begin
			$display("Fail at %0t: system_reset low during download", $time);
			error_count++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	//////////////////////////////
	// Host side
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (ioctl_wait && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (ioctl_wait) begin
			$display("ioctl_wait stuck high for %0d cycles at %0t", WAIT_LIMIT, $time);
			error_count++;
		end
	endtask

	// Waits for the write master to put a word on the bus
	task automatic wait_awvalid();
		int cycles;
		cycles = 0;
		while (!awvalid && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (!awvalid) begin
			$display("awvalid never rose for the pending word at %0t", $time);
			error_count++;
		end
	endtask

	// One host write, then wait for the strobe to reach the packer
	task automatic send_half(input byte_addr_t addr, input half_t data);
		wait_ready();
		ioctl_wr = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		next_cycle();
		ioctl_wr = 1'b0;
		repeat (3) next_cycle();
		wait_ready();
	endtask

	task automatic send_stream(input byte_addr_t base, input int count, input logic random_data);
		half_t      value;
		half_t      first_value;
		byte_addr_t addr;
		byte_addr_t first_addr;
		for (int i = 0; i < count; i++) begin
			addr = base + byte_addr_t'(2 * i);
			if (random_data) begin
				value = half_t'($random(seed));
			end else begin
				value = half_t'(16'h5A00 + 16'h0111 * i);
			end
			if (i % 2 == 0) begin
				first_value = value;
				first_addr = addr;
			end else begin
				// Queued before the word can reach the bus
				expected_q.push_back(expected_word(first_value, value, first_addr));
			end
			send_half(addr, value);
		end
	endtask

	// Returns how long ioctl_wait held the host off
	task automatic start_download(output int pause_cycles);
		int cycles;
		cycles = 0;
		// Sequence rearms only once system reset has fallen
		while (system_reset && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (system_reset) begin
			$display("system_reset never fell before the download at %0t", $time);
			error_count++;
		end
		repeat (2) next_cycle();
		ioctl_download = 1'b1;
		next_cycle();
		pause_cycles = 0;
		while (ioctl_wait && pause_cycles < WAIT_LIMIT) begin
			next_cycle();
			pause_cycles++;
		end
	endtask

	task automatic check_writes(input int writes_before, input int want);
		if (write_count - writes_before != want) begin
			$display("Fail at %0t: %0d writes, expected %0d", $time,
				write_count - writes_before, want);
			error_count++;
		end
		if (expected_q.size() != 0) begin
			$display("Fail at %0t: %0d expected writes missing", $time, expected_q.size());
			error_count++;
			expected_q.delete();
		end
	endtask

	task automatic check_idle();
		if (awvalid || wvalid || ioctl_wait) begin
			$display("Fail at %0t: awvalid %b wvalid %b ioctl_wait %b after hardware reset",
				$time, awvalid, wvalid, ioctl_wait);
			error_count++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		int errors;
		errors = total_errors() - errors_before;
		if (errors == 0) begin
			tests_passed++;
			$display("Test %s finished with no errors", name);
		end else begin
			tests_failed++;
			$display("Test %s finished with %0d errors", name, errors);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int errors_before;
		int writes_before;
		int pause_cycles;
		seed = 20;
		hardware_reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		repeat (5) next_cycle();
		hardware_reset = 1'b0;

		// Host held off through the pause
		errors_before = total_errors();
		start_download(pause_cycles);
		if (pause_cycles < DOWNLOAD_PAUSE_CYCLES) begin
			$display("Fail at %0t: ioctl_wait high %0d cycles, expected at least %0d",
				$time, pause_cycles, DOWNLOAD_PAUSE_CYCLES);
			error_count++;
		end
		end_test("download pause", errors_before);

		// No stalls, plain packing
		errors_before = total_errors();
		writes_before = write_count;
		send_stream(25'h0000400, 16, 1'b0);
		repeat (2) next_cycle();
		check_writes(writes_before, 8);
		end_test("packing", errors_before);

		// Reset hold after the download ends
		errors_before = total_errors();
		ioctl_download = 1'b0;
		repeat (SYSTEM_RESET_CYCLES - 2) next_cycle();
		if (!system_reset) begin
			$display("Fail at %0t: system_reset fell too early", $time);
			error_count++;
		end
		repeat (6) next_cycle();
		if (system_reset) begin
			$display("Fail at %0t: system_reset still high", $time);
			error_count++;
		end
		end_test("system reset", errors_before);

		// Random stalls on every AXI channel
		errors_before = total_errors();
		stall_enable = 1'b1;
		start_download(pause_cycles);
		writes_before = write_count;
		send_stream(25'h1F0000, 16, 1'b1);
		repeat (2) next_cycle();
		check_writes(writes_before, 8);
		ioctl_download = 1'b0;
		end_test("back-pressure", errors_before);

		// Fifth halfword dropped with the download
		errors_before = total_errors();
		start_download(pause_cycles);
		writes_before = write_count;
		send_stream(25'h0A0010, 5, 1'b1);
		repeat (4) next_cycle();
		ioctl_download = 1'b0;
		repeat (20) next_cycle();
		check_writes(writes_before, 2);
		end_test("odd tail", errors_before);

		// Reset while a word is on the AXI bus
		errors_before = total_errors();
		start_download(pause_cycles);
		writes_before = write_count;
		send_stream(25'h0C0000, 3, 1'b0);
		// Fourth halfword completes a word that the reset cuts off
		ioctl_wr = 1'b1;
		ioctl_addr = 25'h0C0006;
		ioctl_dout = 16'hC3C3;
		next_cycle();
		ioctl_wr = 1'b0;
		wait_awvalid();
		hardware_reset = 1'b1;
		repeat (2) next_cycle();
		ioctl_download = 1'b0;
		check_idle();
		repeat (3) next_cycle();
		hardware_reset = 1'b0;
		repeat (40) begin
			next_cycle();
			check_idle();
		end
		check_writes(writes_before, 1);
		end_test("hardware reset", errors_before);

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/rom_loader_assert.sv ====
//////////////////////////////
// Protocol checks on the AXI4-Lite write master and its write bus ack
// Attached to every write master instance by the bind below
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rom_loader_assert (
	input wire                            clk_sys,
	input wire                            hardware_reset,
	input wire                            awvalid,
	input wire                            awready,
	input wire rom_loader_pkg::axi_addr_t awaddr,
	input wire                            wvalid,
	input wire                            wready,
	input wire rom_loader_pkg::word_t     wdata,
	input wire                            bready,
	input wire                            ack
);

	// Count of failed checks
	int failures = 0;

	// Valids stay up until their own ready
	aw_hold: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		awvalid && !awready |=> awvalid)
		else begin
			$error("awvalid dropped before awready");
			failures++;
		end
	w_hold: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		wvalid && !wready |=> wvalid)
		else begin
			$error("wvalid dropped before wready");
			failures++;
		end

	// Payload frozen while it waits
	aw_stable: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		awvalid && !awready |=> $stable(awaddr))
		else begin
			$error("awaddr changed while awvalid waited");
			failures++;
		end
	w_stable: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		wvalid && !wready |=> $stable(wdata))
		else begin
			$error("wdata changed while wvalid waited");
			failures++;
		end

	// Response phase never overlaps the address phase
	b_alone: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		!(bready && awvalid))
		else begin
			$error("bready high together with awvalid");
			failures++;
		end

	// Ack is a single pulse
	ack_pulse: assert property (@(posedge clk_sys) disable iff (hardware_reset)
		ack |=> !ack)
		else begin
			$error("ack held for more than one cycle");
			failures++;
		end

endmodule

bind axil_write_master rom_loader_assert rom_loader_assert_inst (
	.clk_sys        (clk_sys),
	.hardware_reset (hardware_reset),
	.awvalid        (awvalid),
	.awready        (awready),
	.awaddr         (awaddr),
	.wvalid         (wvalid),
	.wready         (wready),
	.wdata          (wdata),
	.bready         (bready),
	.ack            (mem.ack)
);

`default_nettype wire

// ==== design/rom_loader_top.sv ====
//////////////////////////////
// ROM download loader top level
// Host halfwords in, AXI4-Lite word writes and system reset out
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rom_loader_top (
	input  wire                             clk_sys,
	input  wire                             hardware_reset,
	// Host side
	input  wire                             ioctl_download,
	input  wire                             ioctl_wr,
	input  wire rom_loader_pkg::byte_addr_t ioctl_addr,
	input  wire rom_loader_pkg::half_t      ioctl_dout,
	output logic                            ioctl_wait,
	// AXI4-Lite write side
	output rom_loader_pkg::axi_addr_t       awaddr,
	output logic                            awvalid,
	input  wire                             awready,
	output rom_loader_pkg::word_t           wdata,
	output rom_loader_pkg::strb_t           wstrb,
	output logic                            wvalid,
	input  wire                             wready,
	input  wire                             bvalid,
	output logic                            bready,
	// Reset side
	output logic                            system_reset
);
	import rom_loader_pkg::*;

	// Halfword in clk_sys
	logic       half_strobe;
	half_t      half_data;
	byte_addr_t half_addr;

	// Host hold-off sources
	logic packer_wait;
	logic pause_wait;

	// Packer to write master
	rom_write_if rom_write_bus ();

	// Host waits for a pending write or the download pause
	assign ioctl_wait = packer_wait | pause_wait;

	ioctl_sync ioctl_sync_inst (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.half_strobe    (half_strobe),
		.half_data      (half_data),
		.half_addr      (half_addr)
	);

	word_packer word_packer_inst (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.half_strobe    (half_strobe),
		.half_data      (half_data),
		.half_addr      (half_addr),
		.packer_wait    (packer_wait),
		.mem            (rom_write_bus.source)
	);

	axil_write_master axil_write_master_inst (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.awready        (awready),
		.wready         (wready),
		.bvalid         (bvalid),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.bready         (bready),
		.mem            (rom_write_bus.sink)
	);

	reset_sequencer reset_sequencer_inst (
		.clk_sys        (clk_sys),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.pause_wait     (pause_wait),
		.system_reset   (system_reset)
	);

endmodule

`default_nettype wire

// ==== design/reset_sequencer.sv ====
//////////////////////////////
// Reset sequence around a ROM download
// Pauses the host after a download starts, holds system reset past its end
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module reset_sequencer (
	input  wire  clk_sys,
	input  wire  hardware_reset,
	input  wire  ioctl_download,
	output logic pause_wait,
	output logic system_reset
);
	import rom_loader_pkg::*;

	// Set once system reset has run out, cleared by a download start
	logic armed;

	// Cycles spent in the download pause
	count_t pause_count;

	// Cycles since download and pause both ended
	count_t system_count;

	// Held high until the count saturates
	assign system_reset = (system_count != SYSTEM_RESET_CYCLES);

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			armed        <= 1'b0;
			pause_wait   <= 1'b0;
			pause_count  <= '0;
			system_count <= '0;
		end else begin
			//////////////////////////////
			// Download pause
			//////////////////////////////

			// Start of an armed download
			if (ioctl_download && armed) begin
				armed       <= 1'b0;
				pause_wait  <= 1'b1;
				pause_count <= '0;
			end else if (pause_wait) begin
				if (pause_count != DOWNLOAD_PAUSE_CYCLES) begin
					pause_count <= pause_count + 8'd1;
				end else begin
					pause_wait <= 1'b0;
				end
			end

			//////////////////////////////
			// System reset hold
			//////////////////////////////

			// Restarts while download or pause is active
			if (ioctl_download || pause_wait) begin
				system_count <= '0;
			end else if (system_count != SYSTEM_RESET_CYCLES) begin
				system_count <= system_count + 8'd1;
			end else begin
				// Reset has fallen, next download may start a pause
				armed <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/axil_write_master.sv ====
//////////////////////////////
// AXI4-Lite write master, one word in flight
// Takes a word from the write bus and acks it on the write response
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module axil_write_master (
	input  wire                       clk_sys,
	input  wire                       hardware_reset,
	input  wire                       awready,
	input  wire                       wready,
	input  wire                       bvalid,
	output rom_loader_pkg::axi_addr_t awaddr,
	output logic                      awvalid,
	output rom_loader_pkg::word_t     wdata,
	output rom_loader_pkg::strb_t     wstrb,
	output logic                      wvalid,
	output logic                      bready,
	rom_write_if.sink                 mem
);
	import rom_loader_pkg::*;

	axi_state_t state;

	// Channel handshakes already seen
	logic aw_done;
	logic w_done;

	// Channel handshakes seen by the end of this cycle
	logic aw_complete;
	logic w_complete;

	// New word taken from the bus, ack still high means the old word
	logic start;

	assign start = (state == idle) && mem.request && !mem.ack;

	// Both valids rise on entry, each drops on its own ready
	assign awvalid     = (state == address_and_data) && !aw_done;
	assign wvalid      = (state == address_and_data) && !w_done;
	assign aw_complete = aw_done || (awvalid && awready);
	assign w_complete  = w_done || (wvalid && wready);

	assign bready = (state == response);
	assign wstrb  = FULL_STROBE;

	//////////////////////////////
	// Write FSM
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			state   <= idle;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
			mem.ack <= 1'b0;
		end else begin
			mem.ack <= 1'b0;
			case (state)
				idle: begin
					if (start) begin
						aw_done <= 1'b0;
						w_done  <= 1'b0;
						state   <= address_and_data;
					end
				end
				address_and_data: begin
					aw_done <= aw_complete;
					w_done  <= w_complete;
					// Channels finish in any order
					if (aw_complete && w_complete) begin
						state <= response;
					end
				end
				response: begin
					if (bvalid) begin
						mem.ack <= 1'b1;
						state   <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// Address and data held for the whole write
	always_ff @(posedge clk_sys) begin
		if (start) begin
			awaddr <= axi_addr_t'({mem.word_addr, 2'b00});
			wdata  <= mem.data;
		end
	end

endmodule

`default_nettype wire

// ==== design/word_packer.sv ====
//////////////////////////////
// Pairs host halfwords into 32-bit words
// Offers each full word on the write bus and holds the host off until ack
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module word_packer (
	input  wire                             clk_sys,
	input  wire                             hardware_reset,
	input  wire                             ioctl_download,
	input  wire                             half_strobe,
	input  wire rom_loader_pkg::half_t      half_data,
	input  wire rom_loader_pkg::byte_addr_t half_addr,
	output logic                            packer_wait,
	rom_write_if.source                     mem
);
	import rom_loader_pkg::*;

	// Low when the next halfword is the low half
	logic phase;

	// First halfword of the pair
	half_t low_half;

	// Halfword taken this cycle
	logic accept;

	// Nothing is taken while a word waits for its write
	assign accept = ioctl_download && half_strobe && !mem.request;

	// Host wait follows the pending word
	assign packer_wait = mem.request;

	//////////////////////////////
	// Phase and request
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			phase       <= 1'b0;
			mem.request <= 1'b0;
		end else begin
			// Download gone, drop any half-filled word
			if (!ioctl_download) begin
				phase <= 1'b0;
			end else if (accept) begin
				phase <= ~phase;
				// Second half completes the word
				if (phase) begin
					mem.request <= 1'b1;
				end
			end
			// Word written, free the bus a cycle after ack
			if (mem.request && mem.ack) begin
				mem.request <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Word payload
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		// Low half fixes the word address
		if (accept && !phase) begin
			low_half      <= half_data;
			mem.word_addr <= half_addr[$bits(byte_addr_t)-1:2];
		end
		// High half goes above the stored low half
		if (accept && phase) begin
			mem.data <= {half_data, low_half};
		end
	end

endmodule

`default_nettype wire

// ==== design/ioctl_sync.sv ====
//////////////////////////////
// Brings the host write strobe, data and address into clk_sys
// Gives one halfword strobe per host write, aligned with its value
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module ioctl_sync (
	input  wire                             clk_sys,
	input  wire                             hardware_reset,
	input  wire                             ioctl_wr,
	input  wire rom_loader_pkg::byte_addr_t ioctl_addr,
	input  wire rom_loader_pkg::half_t      ioctl_dout,
	output logic                            half_strobe,
	output rom_loader_pkg::half_t           half_data,
	output rom_loader_pkg::byte_addr_t      half_addr
);
	import rom_loader_pkg::*;

	// Strobe history, newest bit at the bottom
	logic [2:0] wr_shift;

	// First stage of the value chain
	half_t      data_stage;
	byte_addr_t addr_stage;

	//////////////////////////////
	// Strobe edge detect
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hardware_reset) begin
			wr_shift <= 3'b000;
		end else begin
			wr_shift <= {wr_shift[1:0], ioctl_wr};
		end
	end

	// Rising edge between stage two and stage three
	assign half_strobe = wr_shift[1] & ~wr_shift[2];

	//////////////////////////////
	// Value chain
	//////////////////////////////

	// Two registers deep, so the value sits next to the strobe
	always_ff @(posedge clk_sys) begin
		data_stage <= ioctl_dout;
		half_data  <= data_stage;
		addr_stage <= ioctl_addr;
		half_addr  <= addr_stage;
	end

endmodule

`default_nettype wire

// ==== design/rom_write_if.sv ====
//////////////////////////////
// One packed word on its way from the packer to the AXI write master
//////////////////////////////

`default_nettype none
`timescale 1ns/10ps

interface rom_write_if;
	import rom_loader_pkg::*;

	// Word address of the packed word
	word_addr_t word_addr;

	// Low half first, high half above it
	word_t data;

	// Held with address and data until ack
	logic request;

	// Single cycle, on the AXI write response
	logic ack;

	// Packer side
	modport source (
		output word_addr,
		output data,
		output request,
		input  ack
	);

	// Write master side
	modport sink (
		input  word_addr,
		input  data,
		input  request,
		output ack
	);

endinterface

`default_nettype wire

// ==== design/rom_loader_pkg.sv ====
//////////////////////////////
// Widths, counts and types shared by the ROM download loader
// Each loader file imports what it needs from here
//////////////////////////////

`default_nettype none

package rom_loader_pkg;

	//////////////////////////////
	// Data and address widths
	//////////////////////////////

	// One halfword as the host sends it
	typedef logic [15:0] half_t;

	// Two halfwords packed for memory
	typedef logic [31:0] word_t;

	// Host byte address
	typedef logic [24:0] byte_addr_t;

	// Byte address without its two low bits
	typedef logic [22:0] word_addr_t;

	// AXI byte address, word address times four
	typedef logic [31:0] axi_addr_t;

	// AXI byte lane enables
	typedef logic [3:0] strb_t;

	// Reset sequence counters
	typedef logic [7:0] count_t;

	//////////////////////////////
	// Reset sequence lengths
	//////////////////////////////

	// Host held off this long after a download starts
	localparam count_t DOWNLOAD_PAUSE_CYCLES = 8'd255;

	// System reset held this long after download and pause end
	localparam count_t SYSTEM_RESET_CYCLES = 8'd255;

	// Every write covers the whole word
	localparam strb_t FULL_STROBE = 4'b1111;

	// Write master states
	typedef enum logic [1:0] {
		idle,
		address_and_data,
		response
	} axi_state_t;

endpackage

`default_nettype wire
